//--- build.f
logic/packet_pkg.sv
logic/axis_to_packet_adapter.sv
logic/packet_skid_buffer.sv
logic/packet_summarizer.sv
logic/packet_adapter_top.sv
verif/packet_adapter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the packet adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module packet_adapter_tb \
    --Mdir obj_dir \
    -o packet_adapter_sim \
    -f build.f

./obj_dir/packet_adapter_sim 2>&1 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- verif/packet_adapter_tb.sv
/*
 * Testbench for the packet adapter subsystem: packet table, summary
 * reference model, ack responder, compare tasks and timeouts
 */
module packet_adapter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import packet_pkg::*;

    localparam int NUM_PKTS      = 28;
    localparam int NUM_FIXED     = 8;
    localparam int READY_TIMEOUT = 200;
    localparam int REQ_TIMEOUT   = 2000;
    localparam int ACK_TIMEOUT   = 50;

    // One table row per packet, err_beat of -1 means no error
    typedef struct packed {
        int         len;
        logic [7:0] meta;
        int         err_beat;
        logic [7:0] gaps;
        int         ack_delay;
        logic       stall;
    } pkt_entry_t;

    logic              __packet_if;
    logic              rst_n;
    axis_beat_t        axis_beat;
    logic              axis_valid;
    logic              axis_ready;
    logic [META_W-1:0] meta;
    logic              err;
    packet_summary_t   summary;
    logic              summary_req;
    logic              summary_ack;

    pkt_entry_t      pkt_table [NUM_PKTS];
    packet_summary_t expected_q [$];
    int              ack_delay_q [$];
    logic            stall_q [$];
    int              acked = 0;
    logic [31:0]     rng;

    packet_adapter_top dut_i (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .axis_beat   (axis_beat),
        .axis_valid  (axis_valid),
        .axis_ready  (axis_ready),
        .meta        (meta),
        .err         (err),
        .summary     (summary),
        .summary_req (summary_req),
        .summary_ack (summary_ack)
    );

    initial begin
        __packet_if = 1'b0;
        forever begin
            #4 __packet_if = ~__packet_if;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Rotate left by one, then fold in the next byte
    function automatic logic [15:0] csum_step(input logic [15:0] c, input logic [7:0] b);
        return {c[14:0], c[15]} ^ {8'h00, b};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_summary(input packet_summary_t got, input packet_summary_t want);
        if (got !== want) begin
            abort_run($sformatf(
                "FAILED summary: got %h expected %h (count %h/%h csum %h/%h err %h/%h meta %h/%h)",
                got, want, got.byte_count, want.byte_count, got.checksum, want.checksum,
                got.err, want.err, got.meta, want.meta));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, want));
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (axis_ready !== 1'b1) begin
            @(negedge __packet_if);
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("Timeout: axis_ready stayed low too long");
            end
        end
    endtask

    task automatic wait_req(input logic level, input int limit);
        int waited;
        waited = 0;
        while (summary_req !== level) begin
            @(negedge __packet_if);
            waited++;
            if (waited > limit) begin
                abort_run($sformatf("Timeout: summary_req never went to %0d", level));
            end
        end
    endtask

    task automatic build_table();
        int len;
        int beats;
        // Hand-picked cases first: full beat, partial tails, errors, back-pressure
        pkt_table[0] = '{8, 8'h11, -1, 8'h00, 0, 1'b0};
        pkt_table[1] = '{13, 8'h22, -1, 8'h00, 2, 1'b0};
        pkt_table[2] = '{23, 8'h33, -1, 8'h05, 1, 1'b0};
        pkt_table[3] = '{17, 8'h44, 1, 8'h00, 3, 1'b0};
        pkt_table[4] = '{1, 8'h55, 0, 8'h00, 0, 1'b0};
        pkt_table[5] = '{31, 8'h66, 3, 8'h0a, 0, 1'b0};
        pkt_table[6] = '{40, 8'h77, -1, 8'h00, 40, 1'b1};
        pkt_table[7] = '{64, 8'h88, -1, 8'h00, 5, 1'b0};
        for (int p = NUM_FIXED; p < NUM_PKTS; p++) begin
            rng   = xorshift32(rng);
            len   = 1 + int'(rng % 32'd70);
            beats = (len + DATA_BYTES - 1) / DATA_BYTES;
            pkt_table[p].len       = len;
            pkt_table[p].meta      = 8'h90 + 8'(p);
            pkt_table[p].gaps      = rng[15:8];
            pkt_table[p].ack_delay = int'(rng[18:16]);
            pkt_table[p].stall     = 1'b0;
            if (rng[19]) begin
                pkt_table[p].err_beat = int'(rng[31:20]) % beats;
            end else begin
                pkt_table[p].err_beat = -1;
            end
        end
    endtask

    // Builds the payload, queues the expected summary, then drives the beats
    task automatic send_packet(input pkt_entry_t e);
        logic [7:0]      bytes [$];
        packet_summary_t want;
        logic [15:0]     csum;
        int              beats;
        int              idx;
        csum = '0;
        for (int i = 0; i < e.len; i++) begin
            rng = xorshift32(rng);
            bytes.push_back(rng[7:0]);
            csum = csum_step(csum, rng[7:0]);
        end
        beats           = (e.len + DATA_BYTES - 1) / DATA_BYTES;
        want.byte_count = COUNT_W'(e.len);
        want.checksum   = csum;
        want.err        = (e.err_beat >= 0);
        want.meta       = e.meta;
        expected_q.push_back(want);
        ack_delay_q.push_back(e.ack_delay);
        stall_q.push_back(e.stall);

        for (int b = 0; b < beats; b++) begin
            if (e.gaps[b % 8]) begin
                axis_valid = 1'b0;
                @(negedge __packet_if);
            end
            rng = xorshift32(rng);
            for (int j = 0; j < DATA_BYTES; j++) begin
                idx = b * DATA_BYTES + j;
                if (idx < e.len) begin
                    axis_beat.tdata[j] = bytes[idx];
                    axis_beat.tkeep[j] = 1'b1;
                end else begin
                    // Junk past the end, must not reach the checksum
                    axis_beat.tdata[j] = rng[8*(j%4) +: 8];
                    axis_beat.tkeep[j] = 1'b0;
                end
            end
            axis_beat.tlast = (b == beats - 1);
            // Later beats carry different meta on purpose
            meta       = (b == 0) ? e.meta : ~e.meta;
            err        = (b == e.err_beat);
            axis_valid = 1'b1;
            wait_ready();
            @(negedge __packet_if);
        end
        axis_valid = 1'b0;
        err        = 1'b0;
    endtask

    task automatic wait_all_acked();
        int waited;
        waited = 0;
        while (acked < NUM_PKTS) begin
            @(negedge __packet_if);
            waited++;
            if (waited > REQ_TIMEOUT) begin
                abort_run("Timeout: not every packet produced a summary");
            end
        end
    endtask

    initial begin : stimulus
        rst_n      = 1'b0;
        axis_beat  = '0;
        axis_valid = 1'b0;
        meta       = '0;
        err        = 1'b0;
        rng        = 32'hbcf4_e046;
        build_table();
        repeat (16) @(posedge __packet_if);
        @(negedge __packet_if);
        check_flag("axis_ready", axis_ready, 1'b0);
        rst_n = 1'b1;
        check_flag("summary_req", summary_req, 1'b0);
        wait_ready();
        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(pkt_table[p]);
        end
        wait_all_acked();
        $display("Result: PASSED");
        $finish;
    end

    // Summary consumer side of the four-phase handshake
    initial begin : ack_side
        packet_summary_t want;
        int              delay;
        logic            stall;
        summary_ack = 1'b0;
        for (int n = 0; n < NUM_PKTS; n++) begin
            wait_req(1'b1, REQ_TIMEOUT);
            if (expected_q.size() == 0) begin
                abort_run("summary_req rose with no packet outstanding");
            end
            want  = expected_q.pop_front();
            delay = ack_delay_q.pop_front();
            stall = stall_q.pop_front();
            check_summary(summary, want);
            repeat (delay) @(negedge __packet_if);
            // Summary held steady for the whole request
            check_flag("summary_req", summary_req, 1'b1);
            check_summary(summary, want);
            if (stall) begin
                check_flag("axis_ready", axis_ready, 1'b0);
            end
            summary_ack = 1'b1;
            wait_req(1'b0, ACK_TIMEOUT);
            summary_ack = 1'b0;
            @(negedge __packet_if);
            acked++;
        end
    end

endmodule : packet_adapter_tb

//--- logic/packet_adapter_top.sv
/*
 * Adapter, skid buffer and summarizer chained into one subsystem
 */
module packet_adapter_top (
    input  logic                          __packet_if,
    input  logic                          rst_n,
    // AXI-S input
    input  packet_pkg::axis_beat_t        axis_beat,
    input  logic                          axis_valid,
    output logic                          axis_ready,
    input  logic [packet_pkg::META_W-1:0] meta,
    input  logic                          err,
    // Summary output
    output packet_pkg::packet_summary_t   summary,
    output logic                          summary_req,
    input  logic                          summary_ack
);
    import packet_pkg::*;

    // Adapter to buffer
    packet_beat_t beat_in;
    logic         wr;
    logic         rdy;

    // Buffer to summarizer
    packet_beat_t beat_out;
    logic         valid;
    logic         take;

    axis_to_packet_adapter adapter_i (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .axis_beat   (axis_beat),
        .axis_valid  (axis_valid),
        .axis_ready  (axis_ready),
        .meta        (meta),
        .err         (err),
        .rdy         (rdy),
        .beat_in     (beat_in),
        .wr          (wr)
    );

    // One skid slot covers the adapter register
    packet_skid_buffer #(
        .skid (1)
    ) buffer_i (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .beat_in     (beat_in),
        .wr          (wr),
        .rdy         (rdy),
        .beat_out    (beat_out),
        .valid       (valid),
        .take        (take)
    );

    packet_summarizer summarizer_i (
        .__packet_if (__packet_if),
        .rst_n       (rst_n),
        .beat_out    (beat_out),
        .valid       (valid),
        .take        (take),
        .summary     (summary),
        .summary_req (summary_req),
        .summary_ack (summary_ack)
    );

endmodule : packet_adapter_top

//--- logic/packet_summarizer.sv
/*
 * Per-packet summary builder: byte count, rotate-xor checksum,
 * error OR and first-beat meta, handed out by four-phase req/ack
 */
module packet_summarizer (
    input  logic                        __packet_if,
    input  logic                        rst_n,
    // Beats from the buffer
    input  packet_pkg::packet_beat_t    beat_out,
    input  logic                        valid,
    output logic                        take,
    // Summary handshake
    output packet_pkg::packet_summary_t summary,
    output logic                        summary_req,
    input  logic                        summary_ack
);
    import packet_pkg::*;

    summ_state_t        state;
    logic [COUNT_W-1:0] byte_count;
    logic [15:0]        checksum;
    logic               err_acc;
    logic [META_W-1:0]  meta_q;
    logic               first;
    logic               accept;
    logic [EMPTY_W:0]   n_valid;

    // Fold the leading n bytes of a beat into the checksum,
    // byte 0 first
    function automatic logic [15:0] beat_checksum(
        input logic [15:0]  seed,
        input packet_data_t data,
        input logic [EMPTY_W:0] n
    );
        logic [15:0] c;
        c = seed;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (i < int'(n)) begin
                c = {c[14:0], c[15]} ^ {8'h00, data[i]};
            end
        end
        return c;
    endfunction

    assign take    = (state == SUMM_COLLECT);
    assign accept  = valid && take;
    assign n_valid = (EMPTY_W + 1)'(DATA_BYTES - int'(beat_out.empty));

    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SUMM_COLLECT;
            byte_count <= '0;
            checksum   <= '0;
            err_acc    <= 1'b0;
            meta_q     <= '0;
            first      <= 1'b1;
        end else begin
            case (state)
                SUMM_COLLECT: begin
                    if (accept) begin
                        byte_count <= byte_count + COUNT_W'(n_valid);
                        checksum   <= beat_checksum(checksum, beat_out.data, n_valid);
                        err_acc    <= err_acc | beat_out.err;
                        first      <= 1'b0;
                        // Meta belongs to the first beat only
                        if (first) begin
                            meta_q <= beat_out.meta;
                        end
                        if (beat_out.eop) begin
                            state <= SUMM_REQ;
                        end
                    end
                end
                SUMM_REQ: begin
                    if (summary_ack) begin
                        state <= SUMM_RELEASE;
                    end
                end
                SUMM_RELEASE: begin
                    // Ack released, start the next packet clean
                    if (!summary_ack) begin
                        state      <= SUMM_COLLECT;
                        byte_count <= '0;
                        checksum   <= '0;
                        err_acc    <= 1'b0;
                        first      <= 1'b1;
                    end
                end
                default: begin
                    state <= SUMM_COLLECT;
                end
            endcase
        end
    end

    // Accumulators hold still from eop until the handshake ends
    assign summary_req = (state == SUMM_REQ);
    assign summary     = '{
        byte_count: byte_count,
        checksum:   checksum,
        err:        err_acc,
        meta:       meta_q
    };

endmodule : packet_summarizer

//--- logic/packet_skid_buffer.sv
/*
 * Circular FIFO of packet beats with skid slots for upstream
 * pipeline stages, registered ready
 */
module packet_skid_buffer #(
    parameter int skid = 1
) (
    input  logic                     __packet_if,
    input  logic                     rst_n,
    // Write side
    input  packet_pkg::packet_beat_t beat_in,
    input  logic                     wr,
    output logic                     rdy,
    // Read side, head of the FIFO
    output packet_pkg::packet_beat_t beat_out,
    output logic                     valid,
    input  logic                     take
);
    import packet_pkg::*;

    localparam int depth   = 2 + skid;
    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    packet_beat_t       mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic [count_w-1:0] count_next;
    logic               push;
    logic               pop;

    // Pointer step with wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = wr;
    assign pop  = valid && take;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rdy    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
            // Keep skid slots free for beats still in flight
            rdy   <= (depth - int'(count_next)) > skid;
        end
    end

    // Storage
    always_ff @(posedge __packet_if) begin
        if (push) begin
            mem[wr_ptr] <= beat_in;
        end
    end

    assign beat_out = mem[rd_ptr];
    assign valid    = (count != '0);

endmodule : packet_skid_buffer

//--- logic/axis_to_packet_adapter.sv
/*
 * AXI-S to packet beat adapter with one register stage,
 * byte reversal to network order and keep to empty conversion
 */
module axis_to_packet_adapter (
    input  logic                          __packet_if,
    input  logic                          rst_n,
    // AXI-S side
    input  packet_pkg::axis_beat_t        axis_beat,
    input  logic                          axis_valid,
    output logic                          axis_ready,
    // Sideband sampled with each beat
    input  logic [packet_pkg::META_W-1:0] meta,
    input  logic                          err,
    // Toward the skid buffer
    input  logic                          rdy,
    output packet_pkg::packet_beat_t      beat_in,
    output logic                          wr
);
    import packet_pkg::*;

    logic accept;

    // Number of clear keep bits, keep assumed contiguous from byte 0
    function automatic logic [EMPTY_W-1:0] keep_to_empty(
        input logic [DATA_BYTES-1:0] keep
    );
        logic [EMPTY_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (!keep[i]) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // Ready comes straight from the buffer, which keeps room for
    // the beat sitting in our register
    assign axis_ready = rdy;
    assign accept     = axis_valid && rdy;

    // Write strobe follows the accept by one cycle
    always_ff @(posedge __packet_if or negedge rst_n) begin
        if (!rst_n) begin
            wr <= 1'b0;
        end else begin
            wr <= accept;
        end
    end

    // Beat register
    always_ff @(posedge __packet_if) begin
        if (accept) begin
            // Byte 0 lands in the top slice
            beat_in.data <= {<<8{axis_beat.tdata}};
            beat_in.eop  <= axis_beat.tlast;
            if (axis_beat.tlast) begin
                beat_in.empty <= keep_to_empty(axis_beat.tkeep);
            end else begin
                beat_in.empty <= '0;
            end
            beat_in.err  <= err;
            beat_in.meta <= meta;
        end
    end

endmodule : axis_to_packet_adapter

//--- logic/packet_pkg.sv
/*
 * Shared widths, beat and summary structs, consumer state enum
 */
package packet_pkg;

    // Beat geometry
    localparam int DATA_BYTES = 8;
    localparam int EMPTY_W    = 3;

    // Per-packet sideband and result widths
    localparam int META_W  = 8;
    localparam int COUNT_W = 16;

    // AXI-S data, byte 0 in the low bits
    typedef logic [DATA_BYTES-1:0][7:0] axis_data_t;

    // Packet data in network order, byte 0 in the top slice
    typedef logic [0:DATA_BYTES-1][7:0] packet_data_t;

    // One beat as it arrives on the AXI-S side
    typedef struct packed {
        axis_data_t            tdata;
        logic [DATA_BYTES-1:0] tkeep;
        logic                  tlast;
    } axis_beat_t;

    // One beat on the internal packet links
    typedef struct packed {
        packet_data_t       data;
        logic               eop;
        // Unused bytes at the tail of the eop beat
        logic [EMPTY_W-1:0] empty;
        logic               err;
        logic [META_W-1:0]  meta;
    } packet_beat_t;

    // Result reported once per packet
    typedef struct packed {
        logic [COUNT_W-1:0] byte_count;
        logic [15:0]        checksum;
        logic               err;
        logic [META_W-1:0]  meta;
    } packet_summary_t;

    // Summarizer FSM
    typedef enum logic [1:0] {
        SUMM_COLLECT,
        SUMM_REQ,
        SUMM_RELEASE
    } summ_state_t;

endpackage : packet_pkg
